// File: source/imul_pkg.sv
/*
 * shared widths, queue depth and step count for the iterative multiplier
 * request and response payload types
 */
`default_nettype none

package imul_pkg;

  // ------------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------------

  // one two's-complement operand
  localparam int operand_w = 32;
  // full signed product
  localparam int result_w = 64;

  // one shift-and-add step per operand bit
  localparam int step_count = operand_w;
  // counter runs 31 down to 0
  localparam int step_cnt_w = 5;

  // entries in each of the two queues
  localparam int queue_depth = 4;

  // ------------------------------------------------------------------------
  // payloads
  // ------------------------------------------------------------------------

  // a sits in the upper half, b in the lower half
  typedef struct packed {
    logic [operand_w-1:0] a;
    logic [operand_w-1:0] b;
  } mul_req_t;

  typedef logic [result_w-1:0] mul_resp_t;

endpackage

`default_nettype wire

// File: source/imul_queue.sv
/*
 * synchronous FIFO with valid/ready on both sides
 * payload type is a parameter, depth comes from the package
 */
`timescale 1ns/1ns
`default_nettype none

module imul_queue #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,

  // write side
  input  payload_t in_data,
  input  logic     in_val,
  output logic     in_rdy,

  // read side
  output payload_t out_data,
  output logic     out_val,
  input  logic     out_rdy
);

  import imul_pkg::*;

  // circular buffer storage
  payload_t entries [queue_depth];

  logic [$clog2(queue_depth)-1:0]   wr_ptr;
  logic [$clog2(queue_depth)-1:0]   rd_ptr;
  // occupancy, needs one extra code for full
  logic [$clog2(queue_depth+1)-1:0] count;

  logic push;
  logic pop;

  // ------------------------------------------------------------------------
  // handshake
  // ------------------------------------------------------------------------

  assign in_rdy  = (count != queue_depth);
  assign out_val = (count != 0);

  assign push = in_val && in_rdy;
  assign pop  = out_val && out_rdy;

  // head entry is visible as soon as it is written, no fall-through
  assign out_data = entries[rd_ptr];

  // ------------------------------------------------------------------------
  // storage and pointers
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at the last entry
      if (push) begin
        wr_ptr <= (wr_ptr == queue_depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == queue_depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/imul_iter_dpath.sv
/*
 * iterative multiplier datapath: operand registers, step counter,
 * accumulator, sign capture and final negation
 */
`timescale 1ns/1ns
`default_nettype none

module imul_iter_dpath (
  input  logic                          clk,
  input  logic                          reset,

  // operands, only sampled on first_step
  input  logic [imul_pkg::operand_w-1:0] req_a,
  input  logic [imul_pkg::operand_w-1:0] req_b,

  // from control
  input  logic                          a_en,
  input  logic                          a_sel,
  input  logic                          b_en,
  input  logic                          b_sel,
  input  logic                          first_step,

  // to control
  output logic                          step_done,

  output logic [imul_pkg::result_w-1:0]  resp_result
);

  import imul_pkg::*;

  // incoming magnitudes
  logic [operand_w-1:0]  mag_a;
  logic [operand_w-1:0]  mag_b;

  // shifted multiplicand, wide enough to reach the top product bit
  logic [result_w-1:0]   a_reg;
  logic [result_w-1:0]   a_next;
  // multiplier, consumed one bit per step from the bottom
  logic [operand_w-1:0]  b_reg;
  logic [operand_w-1:0]  b_next;

  // unsigned partial product
  logic [result_w-1:0]   acc_reg;

  logic [step_cnt_w-1:0] step_cnt;

  // operand signs, kept for the whole operation
  logic                  sign_a_reg;
  logic                  sign_b_reg;
  logic                  neg_result;

  // ------------------------------------------------------------------------
  // operand conversion
  // ------------------------------------------------------------------------

  // two's-complement magnitude
  // -2^31 maps onto 2^31, which still fits as unsigned 32 bits
  assign mag_a = req_a[operand_w-1] ? (~req_a + 1'b1) : req_a;
  assign mag_b = req_b[operand_w-1] ? (~req_b + 1'b1) : req_b;

  // select low loads the magnitude, select high takes the shifted value
  assign a_next = a_sel ? (a_reg << 1) : result_w'(mag_a);
  assign b_next = b_sel ? (b_reg >> 1) : mag_b;

  // ------------------------------------------------------------------------
  // operand registers
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_next;
    end
    if (b_en) begin
      b_reg <= b_next;
    end
  end

  // signs are captured together with the operands
  always_ff @(posedge clk) begin
    if (first_step) begin
      sign_a_reg <= req_a[operand_w-1];
      sign_b_reg <= req_b[operand_w-1];
    end
  end

  // ------------------------------------------------------------------------
  // accumulator
  // ------------------------------------------------------------------------

  // one step: add the multiplicand when the current multiplier bit is set
  always_ff @(posedge clk) begin
    if (first_step) begin
      acc_reg <= '0;
    end else if (a_en && a_sel && b_reg[0]) begin
      acc_reg <= acc_reg + a_reg;
    end
  end

  // ------------------------------------------------------------------------
  // step counter
  // ------------------------------------------------------------------------

  // loads 31 on the load cycle, then counts down once per calc step
  always_ff @(posedge clk) begin
    if (reset) begin
      step_cnt <= '0;
    end else if (first_step) begin
      step_cnt <= step_cnt_w'(step_count - 1);
    end else if (b_en && b_sel) begin
      step_cnt <= step_cnt - 1'b1;
    end
  end

  // control only looks at this while calculating
  assign step_done = (step_cnt == '0);

  // ------------------------------------------------------------------------
  // result
  // ------------------------------------------------------------------------

  // product is negative when exactly one operand was
  assign neg_result  = sign_a_reg ^ sign_b_reg;
  assign resp_result = neg_result ? (~acc_reg + 1'b1) : acc_reg;

endmodule

`default_nettype wire

// File: source/imul_iter_ctrl.sv
/*
 * idle/calc/done FSM for the iterative multiplier
 * drives the datapath enables and both handshakes
 */
`timescale 1ns/1ns
`default_nettype none

module imul_iter_ctrl (
  input  logic clk,
  input  logic reset,

  // request handshake
  input  logic req_val,
  output logic req_rdy,

  // response handshake
  output logic resp_val,
  input  logic resp_rdy,

  // datapath
  input  logic step_done,
  output logic a_en,
  output logic a_sel,
  output logic b_en,
  output logic b_sel,
  output logic first_step
);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_t;

  state_t state;
  state_t state_next;

  logic req_go;
  logic resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // ------------------------------------------------------------------------
  // state register and next state
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle: if (req_go) state_next = st_calc;
      // last step happens on the same edge that leaves calc
      st_calc: if (step_done) state_next = st_done;
      // result is held here under back-pressure
      st_done: if (resp_go) state_next = st_idle;
      default: state_next = st_idle;
    endcase
  end

  // ------------------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------------------

  always_comb begin
    req_rdy    = 1'b0;
    resp_val   = 1'b0;
    a_en       = 1'b0;
    a_sel      = 1'b0;
    b_en       = 1'b0;
    b_sel      = 1'b0;
    first_step = 1'b0;
    case (state)
      st_idle: begin
        req_rdy = 1'b1;
        // load cycle, selects stay low so the magnitudes go in
        first_step = req_go;
        a_en       = req_go;
        b_en       = req_go;
      end
      st_calc: begin
        // shift both registers every cycle
        a_en  = 1'b1;
        a_sel = 1'b1;
        b_en  = 1'b1;
        b_sel = 1'b1;
      end
      st_done: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: source/imul_iter_unit.sv
/* iterative signed multiplier, control FSM plus datapath */
`timescale 1ns/1ns
`default_nettype none

module imul_iter_unit (
  input  logic                          clk,
  input  logic                          reset,

  input  logic [imul_pkg::operand_w-1:0] req_a,
  input  logic [imul_pkg::operand_w-1:0] req_b,
  input  logic                          req_val,
  output logic                          req_rdy,

  output logic [imul_pkg::result_w-1:0]  resp_result,
  output logic                          resp_val,
  input  logic                          resp_rdy
);

  // control to datapath
  logic a_en;
  logic a_sel;
  logic b_en;
  logic b_sel;
  logic first_step;
  // datapath to control
  logic step_done;

  imul_iter_dpath dpath_i (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .a_en        (a_en),
    .a_sel       (a_sel),
    .b_en        (b_en),
    .b_sel       (b_sel),
    .first_step  (first_step),
    .step_done   (step_done),
    .resp_result (resp_result)
  );

  imul_iter_ctrl ctrl_i (
    .clk        (clk),
    .reset      (reset),
    .req_val    (req_val),
    .req_rdy    (req_rdy),
    .resp_val   (resp_val),
    .resp_rdy   (resp_rdy),
    .step_done  (step_done),
    .a_en       (a_en),
    .a_sel      (a_sel),
    .b_en       (b_en),
    .b_sel      (b_sel),
    .first_step (first_step)
  );

endmodule

`default_nettype wire

// File: source/imul_subsystem.sv
/* top level: request queue, iterative multiplier, response queue */
`timescale 1ns/1ns
`default_nettype none

module imul_subsystem (
  input  logic                          clk,
  input  logic                          reset,

  input  logic [imul_pkg::operand_w-1:0] req_a,
  input  logic [imul_pkg::operand_w-1:0] req_b,
  input  logic                          req_val,
  output logic                          req_rdy,

  output logic [imul_pkg::result_w-1:0]  resp_result,
  output logic                          resp_val,
  input  logic                          resp_rdy
);

  import imul_pkg::*;

  // incoming operand pair, packed for the request queue
  mul_req_t  req_msg;
  // request queue to multiplier
  mul_req_t  unit_req_msg;
  logic      unit_req_val;
  logic      unit_req_rdy;
  logic [operand_w-1:0] unit_req_a;
  logic [operand_w-1:0] unit_req_b;
  // multiplier to response queue
  mul_resp_t unit_resp_result;
  logic      unit_resp_val;
  logic      unit_resp_rdy;

  assign req_msg    = '{a: req_a, b: req_b};
  assign unit_req_a = unit_req_msg.a;
  assign unit_req_b = unit_req_msg.b;

  imul_queue #(.payload_t(mul_req_t)) req_queue_i (
    .clk      (clk),
    .reset    (reset),
    .in_data  (req_msg),
    .in_val   (req_val),
    .in_rdy   (req_rdy),
    .out_data (unit_req_msg),
    .out_val  (unit_req_val),
    .out_rdy  (unit_req_rdy)
  );

  imul_iter_unit mul_unit_i (
    .clk         (clk),
    .reset       (reset),
    .req_a       (unit_req_a),
    .req_b       (unit_req_b),
    .req_val     (unit_req_val),
    .req_rdy     (unit_req_rdy),
    .resp_result (unit_resp_result),
    .resp_val    (unit_resp_val),
    .resp_rdy    (unit_resp_rdy)
  );

  // back-pressure reaches the multiplier only once this queue is full
  imul_queue #(.payload_t(mul_resp_t)) resp_queue_i (
    .clk      (clk),
    .reset    (reset),
    .in_data  (unit_resp_result),
    .in_val   (unit_resp_val),
    .in_rdy   (unit_resp_rdy),
    .out_data (resp_result),
    .out_val  (resp_val),
    .out_rdy  (resp_rdy)
  );

endmodule

`default_nettype wire

// File: tests/imul_tb.sv
/*
 * testbench for the signed iterative multiply subsystem
 * operand table with exact products, response stalls, order and stability checks
 */
`timescale 1ns/1ns
`default_nettype none

module imul_tb;

  import imul_pkg::*;

  // operands, idle cycles before the request, resp_rdy low cycles before
  // the response, exact signed product
  typedef struct packed {
    logic [operand_w-1:0] a;
    logic [operand_w-1:0] b;
    int                   gap;
    int                   stall;
    logic [result_w-1:0]  prod;
  } row_t;

  // stalls this long must back up both queues
  localparam int long_stall     = 100;
  localparam int rand_stall_max = 3;

  logic                 clk;
  logic                 reset;
  logic [operand_w-1:0] req_a;
  logic [operand_w-1:0] req_b;
  logic                 req_val;
  logic                 req_rdy;
  logic [result_w-1:0]  resp_result;
  logic                 resp_val;
  logic                 resp_rdy;

  row_t                 rows [$];
  int                   error_count;
  int                   sent_count;
  int                   recv_count;
  int                   cycle_count;
  int                   timeout_limit;
  // response seen at the last negedge that could not transfer
  logic                 hold_prev;
  logic [result_w-1:0]  result_prev;

  imul_subsystem dut_i (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // stimulus table
  // ------------------------------------------------------------------------

  task automatic add_row(input logic [31:0] a, input logic [31:0] b, input int gap,
                         input int stall, input logic [63:0] prod);
    row_t r;
    r.a     = a;
    r.b     = b;
    r.gap   = gap;
    r.stall = stall;
    r.prod  = prod;
    rows.push_back(r);
  endtask

  task automatic fill_table();
    // the four sign combinations with gaps between them
    add_row(32'h00000007, 32'hfffffffd, 0, 0,   64'hffffffffffffffeb);
    add_row(32'hfffffff9, 32'h00000003, 2, 0,   64'hffffffffffffffeb);
    add_row(32'hfffffff9, 32'hfffffffd, 5, 4,   64'h0000000000000015);
    // long stall here while the remaining rows go in back to back
    add_row(32'h00000007, 32'h00000003, 0, 300, 64'h0000000000000015);
    add_row(32'h00000000, 32'h12345678, 0, 0,   64'h0000000000000000);
    add_row(32'hdeadbeef, 32'h00000000, 0, 0,   64'h0000000000000000);
    add_row(32'h00000001, 32'h12345678, 0, 0,   64'h0000000012345678);
    add_row(32'hffffffff, 32'h12345678, 0, 0,   64'hffffffffedcba988);
    // most negative operand and largest positive one
    add_row(32'h80000000, 32'h80000000, 0, 0,   64'h4000000000000000);
    add_row(32'h80000000, 32'h00000001, 0, 0,   64'hffffffff80000000);
    add_row(32'h7fffffff, 32'h7fffffff, 0, 0,   64'h3fffffff00000001);
    add_row(32'h80000000, 32'h7fffffff, 0, 0,   64'hc000000080000000);
    add_row(32'h000003e8, 32'h000003e8, 0, 1,   64'h00000000000f4240);
    add_row(32'hffffffff, 32'hffffffff, 0, 0,   64'h0000000000000001);
    add_row(32'h00010000, 32'h00010000, 3, 2,   64'h0000000100000000);
    add_row(32'hfffffffb, 32'h00001000, 0, 0,   64'hffffffffffffb000);
  endtask

  // table stall plus the random extra
  function automatic int largest_stall();
    int m;
    m = 0;
    foreach (rows[i]) begin
      if (rows[i].stall > m) m = rows[i].stall;
    end
    return m + rand_stall_max;
  endfunction

  // ------------------------------------------------------------------------
  // request and response sides
  // ------------------------------------------------------------------------

  // drives 1 ns after the edge and judges the handshake at the negedge before
  task automatic run_requests();
    int   i;
    logic accepted;
    for (i = 0; i < rows.size(); i++) begin
      if (rows[i].gap > 0) begin
        req_val = 1'b0;
        repeat (rows[i].gap) begin
          @(posedge clk);
          #1;
        end
      end
      req_a    = rows[i].a;
      req_b    = rows[i].b;
      req_val  = 1'b1;
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        accepted = req_rdy;
        // a refusal needs a full request queue behind it
        if (!req_rdy && (sent_count - recv_count < queue_depth)) begin
          $display("req_rdy low with only %0d requests pending", sent_count - recv_count);
          error_count++;
        end
        @(posedge clk);
        #1;
      end
      sent_count++;
    end
    req_val = 1'b0;
  endtask

  task automatic run_responses();
    int                  i;
    int                  stall;
    logic                got;
    logic [result_w-1:0] seen;
    for (i = 0; i < rows.size(); i++) begin
      stall = rows[i].stall + int'($urandom_range(rand_stall_max, 0));
      if (stall > 0) begin
        resp_rdy = 1'b0;
        repeat (stall) begin
          @(posedge clk);
          #1;
        end
        // resp queue, unit in done and req queue all full by now
        if (rows[i].stall >= long_stall) begin
          @(negedge clk);
          if (req_rdy || (sent_count - recv_count != 2 * queue_depth + 1)) begin
            $display("back-pressure did not reach the request side: req_rdy %0b, %0d pending",
                     req_rdy, sent_count - recv_count);
            error_count++;
          end
          @(posedge clk);
          #1;
        end
        resp_rdy = 1'b1;
      end
      got = 1'b0;
      while (!got) begin
        @(negedge clk);
        got  = resp_val;
        seen = resp_result;
        @(posedge clk);
        #1;
      end
      recv_count++;
      if (seen !== rows[i].prod) begin
        $display("[ERROR] resp_result row %0d expected %h got %h", i, rows[i].prod, seen);
        error_count++;
      end
    end
  endtask

  // a stalled response keeps valid and data until it transfers
  always @(negedge clk) begin
    if (reset) begin
      hold_prev = 1'b0;
    end else begin
      if (hold_prev && !resp_val) begin
        $display("resp_val dropped before the response transferred");
        error_count++;
      end
      if (hold_prev && resp_val && resp_result !== result_prev) begin
        $display("[ERROR] resp_result changed while stalled, expected %h got %h",
                 result_prev, resp_result);
        error_count++;
      end
      hold_prev   = resp_val && !resp_rdy;
      result_prev = resp_result;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_limit) begin
      $display("timeout after %0d cycles, %0d of %0d responses received",
               cycle_count, recv_count, rows.size());
      $display("Something failed");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------

  initial begin
    void'($urandom(32'hd53944b4));
    error_count = 0;
    sent_count  = 0;
    recv_count  = 0;
    cycle_count = 0;
    hold_prev   = 1'b0;
    result_prev = '0;
    reset       = 1'b1;
    req_a       = '0;
    req_b       = '0;
    req_val     = 1'b0;
    resp_rdy    = 1'b1;
    fill_table();
    timeout_limit = rows.size() * (40 + largest_stall()) + 100;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    // both queues empty after reset
    @(negedge clk);
    if (resp_val !== 1'b0) begin
      $display("[ERROR] resp_val expected 0 got %h", resp_val);
      error_count++;
    end
    if (req_rdy !== 1'b1) begin
      $display("[ERROR] req_rdy expected 1 got %h", req_rdy);
      error_count++;
    end
    @(posedge clk);
    #1;
    fork
      run_requests();
      run_responses();
    join
    // nothing may come out once every row has been answered
    repeat (40) begin
      @(negedge clk);
      if (resp_val) begin
        $display("unexpected extra response %h after the last row", resp_result);
        error_count++;
      end
    end
    $display("responses %0d of %0d, errors %0d", recv_count, rows.size(), error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
source/imul_pkg.sv
source/imul_queue.sv
source/imul_iter_dpath.sv
source/imul_iter_ctrl.sv
source/imul_iter_unit.sv
source/imul_subsystem.sv
tests/imul_tb.sv

// File: Makefile
# build and run the multiply subsystem testbench with Verilator

VERILATOR ?= verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = imul_tb
FILELIST  = project.f
SIM       = obj_dir/V$(TOP)
PASS_MSG  = Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

# the run passes only if the pass message shows up as a line of its own
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
